// ==== logic/cpuPkg.sv ====
package cpuPkg;

    // Word carried by the bus, the registers and the memory
    typedef logic [31:0] wordT;

    // General register index
    typedef logic [3:0] regIdxT;

    // Instruction field positions
    localparam int OpcodeMsb = 31;
    localparam int OpcodeLsb = 27;
    localparam int RaMsb = 26;
    localparam int RaLsb = 23;
    localparam int RbMsb = 22;
    localparam int RbLsb = 19;
    // Signed constant C sits in the low bits
    localparam int ConstWidth = 19;

    // Supported opcodes, anything else halts
    typedef enum logic [4:0] {
        OpLd   = 5'b00000,
        OpLdi  = 5'b00001,
        OpSt   = 5'b00010,
        OpOut  = 5'b10110,
        OpHalt = 5'b11011
    } opcodeT;

    // Control phases, one per clock
    typedef enum logic [3:0] {
        Idle   = 4'd0,
        T0     = 4'd1,
        T1     = 4'd2,
        T2     = 4'd3,
        T3     = 4'd4,
        T4     = 4'd5,
        T5     = 4'd6,
        T6     = 4'd7,
        T7     = 4'd8,
        Halted = 4'd9
    } phaseT;

    // Unit that drives the shared bus
    typedef enum logic [2:0] {
        BusPc    = 3'd0,
        BusMdr   = 3'd1,
        BusZLow  = 3'd2,
        BusReg   = 3'd3,
        BusConst = 3'd4
    } busSrcT;

endpackage

// ==== logic/controlSequencer.sv ====
`timescale 1ns/100ps

module controlSequencer import cpuPkg::*; (
    input  logic   Clock,
    input  logic   rstN,
    input  opcodeT irOpcode,
    output logic   pcOut,
    output logic   incPc,
    output logic   pcEnable,
    output logic   marEnable,
    output logic   read,
    output logic   mdrEnable,
    output logic   irEnable,
    output logic   yEnable,
    output logic   zEnable,
    output logic   ramWriteEnable,
    output logic   outPortEnable,
    output logic   gra,
    output logic   grb,
    output logic   rIn,
    output logic   baOut,
    output logic   halted,
    output busSrcT busSrc
);

    phaseT phase;
    phaseT nextPhase;

    // Phase register
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            phase <= Idle;
        end else begin
            phase <= nextPhase;
        end
    end

    // Step through the phases, short instructions return to T0 early
    always_comb begin
        nextPhase = phase;
        case (phase)
            Idle: nextPhase = T0;
            T0:   nextPhase = T1;
            T1:   nextPhase = T2;
            T2:   nextPhase = T3;
            T3: begin
                // IR is valid from here on
                case (irOpcode)
                    OpLd, OpLdi, OpSt: nextPhase = T4;
                    OpOut:             nextPhase = T0;
                    default:           nextPhase = Halted;
                endcase
            end
            T4:   nextPhase = T5;
            T5:   nextPhase = (irOpcode == OpLdi) ? T0 : T6;
            T6:   nextPhase = T7;
            T7:   nextPhase = T0;
            // Stays here until reset
            Halted: nextPhase = Halted;
            default: nextPhase = Halted;
        endcase
    end

    // Strobe decode, one bus transfer per phase
    always_comb begin
        pcOut          = 1'b0;
        incPc          = 1'b0;
        pcEnable       = 1'b0;
        marEnable      = 1'b0;
        read           = 1'b0;
        mdrEnable      = 1'b0;
        irEnable       = 1'b0;
        yEnable        = 1'b0;
        zEnable        = 1'b0;
        ramWriteEnable = 1'b0;
        outPortEnable  = 1'b0;
        gra            = 1'b0;
        grb            = 1'b0;
        rIn            = 1'b0;
        baOut          = 1'b0;
        busSrc         = BusPc;
        case (phase)
            T0: begin
                // Fetch address out, PC steps to the next word
                pcOut     = 1'b1;
                marEnable = 1'b1;
                incPc     = 1'b1;
                pcEnable  = 1'b1;
                busSrc    = BusPc;
            end
            T1: begin
                read      = 1'b1;
                mdrEnable = 1'b1;
            end
            T2: begin
                irEnable = 1'b1;
                busSrc   = BusMdr;
            end
            T3: begin
                busSrc = BusReg;
                if (irOpcode == OpOut) begin
                    gra           = 1'b1;
                    outPortEnable = 1'b1;
                end else if (irOpcode inside {OpLd, OpLdi, OpSt}) begin
                    // Base register, R0 reads as zero
                    grb     = 1'b1;
                    baOut   = 1'b1;
                    yEnable = 1'b1;
                end
            end
            T4: begin
                // Effective address Y plus C into Z
                busSrc  = BusConst;
                zEnable = 1'b1;
            end
            T5: begin
                busSrc = BusZLow;
                if (irOpcode == OpLdi) begin
                    gra = 1'b1;
                    rIn = 1'b1;
                end else begin
                    marEnable = 1'b1;
                end
            end
            T6: begin
                mdrEnable = 1'b1;
                if (irOpcode == OpSt) begin
                    // Store data from Ra
                    gra    = 1'b1;
                    busSrc = BusReg;
                end else begin
                    read = 1'b1;
                end
            end
            T7: begin
                if (irOpcode == OpSt) begin
                    ramWriteEnable = 1'b1;
                end else begin
                    busSrc = BusMdr;
                    gra    = 1'b1;
                    rIn    = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign halted = (phase == Halted);

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/100ps

module registerFile import cpuPkg::*; (
    input  logic Clock,
    input  logic rstN,
    input  wordT ir,
    input  logic gra,
    input  logic grb,
    input  logic rIn,
    input  logic baOut,
    input  wordT busIn,
    output wordT regOut
);

    wordT   regs [16];
    regIdxT raIdx;
    regIdxT rbIdx;
    regIdxT selIdx;

    // Register fields of IR
    assign raIdx = ir[RaMsb:RaLsb];
    assign rbIdx = ir[RbMsb:RbLsb];

    // Gra wins, Grb picks the base, otherwise R0
    always_comb begin
        if (gra) begin
            selIdx = raIdx;
        end else if (grb) begin
            selIdx = rbIdx;
        end else begin
            selIdx = '0;
        end
    end

    // Write from the bus into the selected register
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[selIdx] <= busIn;
        end
    end

    // Base address of R0 is zero
    always_comb begin
        if (baOut && selIdx == '0) begin
            regOut = '0;
        end else begin
            regOut = regs[selIdx];
        end
    end

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/100ps

module datapath import cpuPkg::*; #(
    parameter int MemAddrWidth = 9
) (
    input  logic                    Clock,
    input  logic                    rstN,
    input  logic                    pcOut,
    input  logic                    incPc,
    input  logic                    pcEnable,
    input  logic                    marEnable,
    input  logic                    read,
    input  logic                    mdrEnable,
    input  logic                    irEnable,
    input  logic                    yEnable,
    input  logic                    zEnable,
    input  logic                    ramWriteEnable,
    input  logic                    outPortEnable,
    input  logic                    rIn,
    input  busSrcT                  busSrc,
    input  wordT                    regOut,
    input  wordT                    memData,
    output wordT                    ir,
    output logic [MemAddrWidth-1:0] marAddr,
    output wordT                    mdrData,
    output wordT                    busValue,
    output wordT                    outData,
    output logic                    outStrobe
);

    wordT pc;
    wordT mar;
    wordT mdr;
    wordT y;
    wordT z;
    wordT constExt;
    wordT busSel;
    logic memPending;
    logic busActive;

    // Sign-extended constant C
    assign constExt = {{($bits(wordT) - ConstWidth){ir[ConstWidth-1]}}, ir[ConstWidth-1:0]};

    // Bus source select
    always_comb begin
        case (busSrc)
            BusPc:    busSel = pcOut ? pc : '0;
            // Fresh memory word shows up while MDR catches it
            BusMdr:   busSel = memPending ? memData : mdr;
            BusZLow:  busSel = z;
            BusReg:   busSel = regOut;
            BusConst: busSel = constExt;
            default:  busSel = '0;
        endcase
    end

    // Bus idles at zero when nothing takes it
    assign busActive = marEnable | irEnable | yEnable | zEnable | rIn | outPortEnable
                     | (mdrEnable & ~read) | (pcEnable & ~incPc);
    assign busValue = busActive ? busSel : '0;

    // PC steps by one word, or loads from the bus
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcEnable) begin
            pc <= incPc ? pc + 1 : busValue;
        end
    end

    // IR holds the opcode seen by the sequencer
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            ir <= '0;
        end else if (irEnable) begin
            ir <= busValue;
        end
    end

    // Memory word arrives one cycle after the read request
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            memPending <= 1'b0;
        end else begin
            memPending <= read & mdrEnable;
        end
    end

    always_ff @(posedge Clock) begin
        if (marEnable) begin
            mar <= busValue;
        end
        if (memPending) begin
            mdr <= memData;
        end else if (mdrEnable && !read && !ramWriteEnable) begin
            mdr <= busValue;
        end
        if (yEnable) begin
            y <= busValue;
        end
        // Address adder
        if (zEnable) begin
            z <= y + busValue;
        end
        if (outPortEnable) begin
            outData <= busValue;
        end
    end

    // Strobe for the out port, one cycle behind the load
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= outPortEnable;
        end
    end

    assign marAddr = mar[MemAddrWidth-1:0];
    assign mdrData = mdr;

endmodule

// ==== logic/wordMemory.sv ====
`timescale 1ns/100ps

module wordMemory import cpuPkg::*; #(
    parameter int MemAddrWidth = 9
) (
    input  logic                    Clock,
    input  logic [MemAddrWidth-1:0] marAddr,
    input  logic                    read,
    input  logic                    ramWriteEnable,
    input  wordT                    mdrData,
    input  logic                    progStrobe,
    input  logic [MemAddrWidth-1:0] progAddr,
    input  wordT                    progData,
    output wordT                    memData
);

    localparam int Depth = 2 ** MemAddrWidth;

    wordT mem [Depth];

    // Program load port first, it only runs in reset
    always_ff @(posedge Clock) begin
        if (progStrobe) begin
            mem[progAddr] <= progData;
        end else if (ramWriteEnable) begin
            mem[marAddr] <= mdrData;
        end
    end

    // Registered read, word valid the next cycle
    always_ff @(posedge Clock) begin
        if (read) begin
            memData <= mem[marAddr];
        end
    end

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore import cpuPkg::*; #(
    parameter int MemAddrWidth = 9
) (
    input  logic                    Clock,
    input  logic                    rstN,
    input  logic                    progStrobe,
    input  logic [MemAddrWidth-1:0] progAddr,
    input  wordT                    progData,
    output wordT                    outData,
    output logic                    outStrobe,
    output logic                    halted
);

    // Control strobes
    logic   pcOut;
    logic   incPc;
    logic   pcEnable;
    logic   marEnable;
    logic   read;
    logic   mdrEnable;
    logic   irEnable;
    logic   yEnable;
    logic   zEnable;
    logic   ramWriteEnable;
    logic   outPortEnable;
    logic   gra;
    logic   grb;
    logic   rIn;
    logic   baOut;
    busSrcT busSrc;

    // Datapath wires
    wordT                    ir;
    wordT                    regOut;
    wordT                    memData;
    wordT                    mdrData;
    wordT                    busValue;
    logic [MemAddrWidth-1:0] marAddr;

    controlSequencer seq0 (
        .Clock(Clock),
        .rstN(rstN),
        .irOpcode(opcodeT'(ir[OpcodeMsb:OpcodeLsb])),
        .pcOut(pcOut),
        .incPc(incPc),
        .pcEnable(pcEnable),
        .marEnable(marEnable),
        .read(read),
        .mdrEnable(mdrEnable),
        .irEnable(irEnable),
        .yEnable(yEnable),
        .zEnable(zEnable),
        .ramWriteEnable(ramWriteEnable),
        .outPortEnable(outPortEnable),
        .gra(gra),
        .grb(grb),
        .rIn(rIn),
        .baOut(baOut),
        .halted(halted),
        .busSrc(busSrc)
    );

    registerFile regs0 (
        .Clock(Clock),
        .rstN(rstN),
        .ir(ir),
        .gra(gra),
        .grb(grb),
        .rIn(rIn),
        .baOut(baOut),
        .busIn(busValue),
        .regOut(regOut)
    );

    datapath #(.MemAddrWidth(MemAddrWidth)) path0 (
        .Clock(Clock),
        .rstN(rstN),
        .pcOut(pcOut),
        .incPc(incPc),
        .pcEnable(pcEnable),
        .marEnable(marEnable),
        .read(read),
        .mdrEnable(mdrEnable),
        .irEnable(irEnable),
        .yEnable(yEnable),
        .zEnable(zEnable),
        .ramWriteEnable(ramWriteEnable),
        .outPortEnable(outPortEnable),
        .rIn(rIn),
        .busSrc(busSrc),
        .regOut(regOut),
        .memData(memData),
        .ir(ir),
        .marAddr(marAddr),
        .mdrData(mdrData),
        .busValue(busValue),
        .outData(outData),
        .outStrobe(outStrobe)
    );

    // Program load goes straight to the memory
    wordMemory #(.MemAddrWidth(MemAddrWidth)) mem0 (
        .Clock(Clock),
        .marAddr(marAddr),
        .read(read),
        .ramWriteEnable(ramWriteEnable),
        .mdrData(mdrData),
        .progStrobe(progStrobe),
        .progAddr(progAddr),
        .progData(progData),
        .memData(memData)
    );

endmodule

// ==== bench/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

    localparam int MemAddrWidth = 9;
    localparam int MemDepth = 2 ** MemAddrWidth;
    localparam int ClockPeriod = 40;
    localparam int ResetCycles = 4;
    // Data words live in the top quarter of memory
    localparam int DataBase = MemDepth * 3 / 4;
    localparam int DataSize = 64;
    localparam int RandomCount = 40;
    localparam int HaltedCycles = 20;

    logic                    Clock;
    logic                    rstN;
    logic                    progStrobe;
    logic [MemAddrWidth-1:0] progAddr;
    wordT                    progData;
    wordT                    outData;
    logic                    outStrobe;
    logic                    halted;

    // Memory image and expected out values
    wordT progImage [MemDepth];
    bit   progValid [MemDepth];
    wordT expectedOuts [$];
    int   instrCount;
    int   totalExpected;
    time  timeLimit;
    logic programReady;

    cpuCore #(.MemAddrWidth(MemAddrWidth)) dut0 (
        .Clock(Clock),
        .rstN(rstN),
        .progStrobe(progStrobe),
        .progAddr(progAddr),
        .progData(progData),
        .outData(outData),
        .outStrobe(outStrobe),
        .halted(halted)
    );

    initial begin
        Clock = 1'b0;
        forever begin
            #(ClockPeriod / 2) Clock = ~Clock;
        end
    end

    task automatic stopWithFailure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkWord(string name, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            stopWithFailure();
        end
    endtask

    // Opcode, Ra, Rb, then the low bits of C
    function automatic wordT encodeInstr(opcodeT op, regIdxT ra, regIdxT rb, int c);
        wordT cw;
        cw = c;
        return {op, ra, rb, cw[ConstWidth-1:0]};
    endfunction

    function automatic void addInstr(opcodeT op, regIdxT ra, regIdxT rb, int c);
        progImage[instrCount] = encodeInstr(op, ra, rb, c);
        progValid[instrCount] = 1'b1;
        instrCount++;
    endfunction

    // Mixes every address bit into the word
    function automatic wordT dataPattern(int addr);
        return (wordT'(addr) * 32'h9E3779B1) ^ 32'hC3A50000;
    endfunction

    function automatic void buildProgram();
        integer seed;
        int     kind;
        int     ra;
        int     rb;
        int     off;
        int     c;
        seed = 70456;
        instrCount = 0;
        for (int a = DataBase; a < DataBase + DataSize; a++) begin
            progImage[a] = dataPattern(a);
            progValid[a] = 1'b1;
        end
        // ldi from R0, then register base with negative C
        addInstr(OpLdi, 1, 0, DataBase);
        addInstr(OpOut, 1, 0, 0);
        addInstr(OpLdi, 2, 1, -5);
        addInstr(OpOut, 2, 0, 0);
        addInstr(OpLdi, 3, 0, -1000);
        addInstr(OpOut, 3, 0, 0);
        // ld with positive and negative offsets, and absolute
        addInstr(OpLd, 4, 1, 10);
        addInstr(OpOut, 4, 0, 0);
        addInstr(OpLdi, 6, 0, DataBase + 56);
        addInstr(OpLd, 5, 6, -7);
        addInstr(OpOut, 5, 0, 0);
        addInstr(OpLd, 7, 0, DataBase + 16);
        addInstr(OpOut, 7, 0, 0);
        // Store, read back, overwrite, read back
        addInstr(OpLdi, 8, 0, 'h12345);
        addInstr(OpSt, 8, 1, 20);
        addInstr(OpLd, 9, 1, 20);
        addInstr(OpOut, 9, 0, 0);
        addInstr(OpLdi, 8, 0, -77);
        addInstr(OpSt, 8, 0, DataBase + 20);
        addInstr(OpLd, 10, 1, 20);
        addInstr(OpOut, 10, 0, 0);
        // Random mix never writes R1 so it keeps the data base
        for (int n = 0; n < RandomCount; n++) begin
            kind = $unsigned($random(seed)) % 3;
            off = $unsigned($random(seed)) % DataSize;
            rb = $unsigned($random(seed)) % 2;
            // R0 base needs the absolute address
            c = (rb == 1) ? off : DataBase + off;
            if (kind == 0) begin
                ra = 2 + $unsigned($random(seed)) % 14;
                rb = $unsigned($random(seed)) % 16;
                c = $random(seed) % (1 << (ConstWidth - 1));
                addInstr(OpLdi, ra, rb, c);
            end else if (kind == 1) begin
                ra = 2 + $unsigned($random(seed)) % 14;
                addInstr(OpLd, ra, rb, c);
            end else begin
                ra = $unsigned($random(seed)) % 16;
                addInstr(OpSt, ra, rb, c);
            end
        end
        // Dump every register, then stop
        for (int r = 0; r < 16; r++) begin
            addInstr(OpOut, r, 0, 0);
        end
        addInstr(OpHalt, 0, 0, 0);
    endfunction

    // Instruction-level model of the program
    function automatic void runProgram();
        wordT       model [MemDepth];
        wordT       modelRegs [16];
        wordT       instr;
        wordT       base;
        wordT       addr;
        int         pc;
        int         steps;
        logic [4:0] op;
        regIdxT     ra;
        regIdxT     rb;
        bit         running;
        for (int i = 0; i < MemDepth; i++) begin
            model[i] = progImage[i];
        end
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        pc = 0;
        steps = 0;
        running = 1'b1;
        while (running && steps < MemDepth * 4) begin
            instr = model[pc % MemDepth];
            pc++;
            steps++;
            op = instr[OpcodeMsb:OpcodeLsb];
            ra = instr[RaMsb:RaLsb];
            rb = instr[RbMsb:RbLsb];
            // R0 as a base reads zero
            if (rb == 0) begin
                base = '0;
            end else begin
                base = modelRegs[rb];
            end
            addr = base + {{($bits(wordT) - ConstWidth){instr[ConstWidth-1]}},
                           instr[ConstWidth-1:0]};
            case (op)
                OpLdi:   modelRegs[ra] = addr;
                OpLd:    modelRegs[ra] = model[addr[MemAddrWidth-1:0]];
                OpSt:    model[addr[MemAddrWidth-1:0]] = modelRegs[ra];
                OpOut:   expectedOuts.push_back(modelRegs[ra]);
                default: running = 1'b0;
            endcase
        end
    endfunction

    // Program load under reset, then release
    initial begin : stimulus
        rstN = 1'b0;
        progStrobe = 1'b0;
        progAddr = '0;
        progData = '0;
        programReady = 1'b0;
        buildProgram();
        runProgram();
        totalExpected = expectedOuts.size();
        // Load and reset cycles plus 8 cycles per instruction and a margin
        timeLimit = (instrCount + DataSize + ResetCycles + 2 + instrCount * 8 + 100)
                  * ClockPeriod;
        programReady = 1'b1;
        for (int a = 0; a < MemDepth; a++) begin
            if (progValid[a]) begin
                @(posedge Clock);
                progStrobe <= 1'b1;
                progAddr   <= a[MemAddrWidth-1:0];
                progData   <= progImage[a];
            end
        end
        @(posedge Clock);
        progStrobe <= 1'b0;
        // Reset stays low four more cycles after the load
        repeat (ResetCycles) @(posedge Clock);
        rstN <= 1'b1;
    end

    // Outputs sampled on the falling edge
    initial begin : compareOuts
        int   cycle;
        int   seen;
        wordT expected;
        cycle = 0;
        seen = 0;
        wait (rstN === 1'b1);
        while (halted !== 1'b1) begin
            @(negedge Clock);
            cycle++;
            // The first out cannot strobe this early
            if (cycle <= 8) begin
                checkFlag("outStrobe", 1'b0, outStrobe);
            end
            // No halt before the first out value
            if (seen == 0) begin
                checkFlag("halted", 1'b0, halted);
            end
            if (outStrobe === 1'b1) begin
                if (expectedOuts.size() == 0) begin
                    $display("An out strobe came after all expected values were seen");
                    stopWithFailure();
                end else begin
                    expected = expectedOuts.pop_front();
                    checkWord("outData", expected, outData);
                    seen++;
                end
            end
        end
        // Halted holds and the out port stays silent
        repeat (HaltedCycles) begin
            @(negedge Clock);
            checkFlag("halted", 1'b1, halted);
            checkFlag("outStrobe", 1'b0, outStrobe);
        end
        if (seen == totalExpected) begin
            $display("No errors");
            $finish;
        end else begin
            $display("The core gave %0d out values, %0d were expected", seen, totalExpected);
            stopWithFailure();
        end
    end

    initial begin : watchdog
        wait (programReady === 1'b1);
        #(timeLimit);
        $display("Timeout: the core did not halt in time");
        stopWithFailure();
    end

endmodule

// ==== sources.f ====
logic/cpuPkg.sv
logic/controlSequencer.sv
logic/registerFile.sv
logic/datapath.sv
logic/wordMemory.sv
logic/cpuCore.sv
bench/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - logic/cpuPkg.sv
  - logic/controlSequencer.sv
  - logic/registerFile.sv
  - logic/datapath.sv
  - logic/wordMemory.sv
  - logic/cpuCore.sv
  - target: test
    files:
      - bench/cpuTb.sv
